//--- compile.f
verilog/tlbPkg.sv
verilog/tlbEntryArray.sv
verilog/tlbLookup.sv
verilog/tlbMaint.sv
verilog/tlb16.sv
dv/tlb16Tb.sv

//--- Makefile
TOP := tlb16Tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

# Verilator returns a failing status when the run ends in $fatal
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- dv/tlb16Tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb16Tb;

	import tlbPkg::*;

	localparam int          CLK_PERIOD   = 40;
	localparam int          DRIVE_DLY    = 2;      // After the rising edge
	localparam int          RESET_CYCLES = 5;
	localparam int          CYCLE_LIMIT  = 2000;   // Tests run about 110 cycles
	localparam logic [31:0] LFSR_SEED    = 32'h7d5c_1986;

	logic        clk;
	logic        rstN;
	vaddrT       instVaddr;
	vaddrT       dataVaddr;
	logic        drd;
	logic        dwe;
	tlbOpT       op;
	cp0InT       cp0In;
	xlateResultT instResult;
	xlateResultT dataResult;
	cp0ViewT     cp0View;

	logic [31:0] lfsrState;
	tlbEntryT    modelEntry [TLB_ENTRIES];   // Mirror of every write
	logic        modelPres [TLB_ENTRIES];
	vpn2T        usedVpn2 [$];               // Keeps every VPN2 distinct
	tlbIdxT      lastIndex;                  // Expected readback index
	logic        lastIndexP;
	asidT        baseAsid;
	int          cycleCount = 0;
	string       testName = "reset";

	tlb16 tlb16_i (
		.clk        (clk),
		.rstN       (rstN),
		.instVaddr  (instVaddr),
		.dataVaddr  (dataVaddr),
		.drd        (drd),
		.dwe        (dwe),
		.op         (op),
		.cp0In      (cp0In),
		.instResult (instResult),
		.dataResult (dataResult),
		.cp0View    (cp0View)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			failRun("Timeout: the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic failRun(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkResult(input string what, input xlateResultT expected,
		input xlateResultT actual);
		assert (actual === expected)
			else failRun($sformatf("[FAIL] %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	task automatic checkField(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
			else failRun($sformatf("[FAIL] %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	// Data port with no access raises no flag
	assert property (@(posedge clk) disable iff (!rstN)
		(!drd && !dwe) |-> !(dataResult.refill || dataResult.invalid || dataResult.modified))
		else failRun($sformatf("[FAIL] %s idle data flags: expected 000, actual %b%b%b",
			testName, $sampled(dataResult.refill), $sampled(dataResult.invalid),
			$sampled(dataResult.modified)));

	assert property (@(posedge clk) disable iff (!rstN)
		instResult.refill |-> (instResult.paddr == '0))
		else failRun($sformatf("[FAIL] %s fetch refill paddr: expected 0, actual %h",
			testName, $sampled(instResult.paddr)));

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			val = {val[30:0], lfsrState[0]};   // One step per bit
		end
	endtask

	task automatic freshVpn2(output vpn2T v);
		logic [31:0] bits;
		logic        clash;
		do begin
			takeBits(VPN2_W, bits);
			v = bits[VPN2_W-1:0];
			clash = 1'b0;
			foreach (usedVpn2[i]) begin
				if (usedVpn2[i] == v) clash = 1'b1;
			end
		end while (clash);
		usedVpn2.push_back(v);
	endtask

	task automatic randomEntry(output tlbEntryT e, output logic g0, output logic g1);
		logic [31:0] bits;
		vpn2T        v;
		freshVpn2(v);
		e = '0;
		e.vpn2 = v;
		e.asid = baseAsid;
		takeBits(PFN_W, bits);
		e.pfn0 = bits[PFN_W-1:0];
		takeBits(PFN_W, bits);
		e.pfn1 = bits[PFN_W-1:0];
		takeBits(6, bits);
		{g0, g1, e.d0, e.v0, e.d1, e.v1} = bits[5:0];
	endtask

	// Random half and offset inside a page pair
	task automatic pickAddr(input vpn2T v, output vaddrT va);
		logic [31:0] bits;
		takeBits(13, bits);
		va = {v, bits[12:0]};
	endtask

	function automatic logic modelFind(input vpn2T v, input asidT asid, output tlbIdxT idx);
		logic found;
		found = 1'b0;
		idx = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (modelPres[i] && modelEntry[i].vpn2 == v &&
				(modelEntry[i].g || modelEntry[i].asid == asid)) begin
				found = 1'b1;
				idx = tlbIdxT'(i);
			end
		end
		return found;
	endfunction

	function automatic xlateResultT modelXlate(input vaddrT va, input asidT asid,
		input logic ld, input logic st);
		xlateResultT r;
		tlbIdxT      idx;
		tlbEntryT    e;
		logic        hit;
		logic        odd;
		pfnT         pfn;
		logic        v;
		logic        d;
		hit = modelFind(va[31:13], asid, idx);
		e   = modelEntry[idx];
		odd = va[12];                          // Odd page of the pair
		pfn = odd ? e.pfn1 : e.pfn0;
		v   = odd ? e.v1 : e.v0;
		d   = odd ? e.d1 : e.d0;
		r = '0;
		if (hit) r.paddr = {pfn, va[11:0]};
		if (ld || st) begin
			r.refill   = !hit;
			r.invalid  = hit && !v;
			r.modified = st && hit && v && !d;
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Op stays up until the next drive point
	task automatic writeEntry(input tlbOpT wop, input logic [31:0] sel, input tlbEntryT e,
		input logic g0, input logic g1);
		tlbIdxT idx;
		idx = sel[IDX_W-1:0];
		nextCycle();
		op = wop;
		cp0In.index    = (wop == OP_WRITE_RANDOM) ? ~sel : sel;  // Other word points elsewhere
		cp0In.random   = (wop == OP_WRITE_RANDOM) ? sel : ~sel;
		cp0In.entryHi  = {e.vpn2, 5'b0, e.asid};
		cp0In.entryLo0 = {6'b0, e.pfn0, 3'b0, e.d0, e.v0, g0};
		cp0In.entryLo1 = {6'b0, e.pfn1, 3'b0, e.d1, e.v1, g1};
		e.g = g0 & g1;
		modelEntry[idx] = e;
		modelPres[idx]  = 1'b1;
	endtask

	task automatic checkLookup(input asidT asid, input vaddrT iva, input vaddrT dva,
		input logic ld, input logic st);
		nextCycle();
		op = '0;
		cp0In.entryHi[ASID_W-1:0] = asid;
		instVaddr = iva;
		dataVaddr = dva;
		drd = ld;
		dwe = st;
		@(negedge clk);                        // Combinational result settles by mid-cycle
		checkResult("fetch", modelXlate(iva, asid, 1'b1, 1'b0), instResult);
		checkResult("data", modelXlate(dva, asid, ld, st), dataResult);
	endtask

	task automatic probeCheck(input vpn2T v, input asidT asid);
		tlbIdxT idx;
		logic   found;
		found = modelFind(v, asid, idx);
		if (found) lastIndex = idx;            // Miss keeps the old index
		lastIndexP = !found;
		nextCycle();
		op = OP_PROBE;
		cp0In.entryHi = {v, 5'b0, asid};
		nextCycle();
		op = '0;
		@(negedge clk);
		checkField("probe indexP", 32'(lastIndexP), 32'(cp0View.indexP));
		checkField("probe index", 32'(lastIndex), 32'(cp0View.indexIndex));
	endtask

	task automatic readCheck(input tlbIdxT idx);
		tlbEntryT e;
		e = modelEntry[idx];
		nextCycle();
		op = OP_READ;
		cp0In.index = 32'(idx);
		nextCycle();
		op = '0;
		@(negedge clk);
		checkField("read vpn2", 32'(e.vpn2), 32'(cp0View.entryHiVpn2));
		checkField("read asid", 32'(e.asid), 32'(cp0View.entryHiAsid));
		checkField("read pfn0", 32'(e.pfn0), 32'(cp0View.entryLo0Pfn));
		checkField("read dv0", 32'({e.d0, e.v0}), 32'(cp0View.entryLo0Dv));
		checkField("read pfn1", 32'(e.pfn1), 32'(cp0View.entryLo1Pfn));
		checkField("read dv1", 32'({e.d1, e.v1}), 32'(cp0View.entryLo1Dv));
		checkField("read g", 32'(e.g), 32'(cp0View.entryLoG));
		checkField("read indexP", 32'(lastIndexP), 32'(cp0View.indexP));  // Left as is
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		tlbEntryT    e;
		logic        g0;
		logic        g1;
		logic [31:0] bits;
		vaddrT       iva;
		vaddrT       dva;
		vpn2T        v;
		rstN = 1'b0;
		instVaddr = '0;
		dataVaddr = '0;
		drd = 1'b0;
		dwe = 1'b0;
		op = '0;
		cp0In = '0;
		lfsrState = LFSR_SEED;
		lastIndex = '0;
		lastIndexP = 1'b0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			modelEntry[i] = '0;
			modelPres[i]  = 1'b0;
		end
		takeBits(ASID_W, bits);
		baseAsid = bits[ASID_W-1:0];
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rstN = 1'b1;

		// Empty TLB, everything refills
		for (int k = 0; k < 4; k++) begin
			takeBits(32, bits);
			iva = bits;
			takeBits(32, bits);
			dva = bits;
			checkLookup(baseAsid, iva, dva, k[0], !k[0]);
		end
		takeBits(VPN2_W, bits);
		probeCheck(bits[VPN2_W-1:0], baseAsid);

		testName = "indexed write";
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			randomEntry(e, g0, g1);
			if (i == 5) {g0, g1} = 2'b11;       // Global entry
			if (i == 6) {g0, g1} = 2'b01;       // Only one G bit so still private
			writeEntry(OP_WRITE_INDEX, 32'(i), e, g0, g1);
		end
		for (int k = 0; k < 2 * TLB_ENTRIES; k++) begin
			pickAddr(modelEntry[k % TLB_ENTRIES].vpn2, iva);
			pickAddr(modelEntry[TLB_ENTRIES - 1 - (k % TLB_ENTRIES)].vpn2, dva);
			checkLookup(baseAsid, iva, dva, 1'b1, 1'b0);
		end

		testName = "flags";
		randomEntry(e, g0, g1);
		{e.v0, e.v1, e.d1} = 3'b010;           // Even half invalid and odd half clean
		writeEntry(OP_WRITE_INDEX, 32'd7, e, 1'b0, 1'b0);
		iva = {e.vpn2, 1'b0, 12'h4a8};
		dva = {e.vpn2, 1'b1, 12'h4a8};
		checkLookup(baseAsid, iva, iva, 1'b1, 1'b0);
		checkLookup(baseAsid, iva, iva, 1'b0, 1'b1);
		checkLookup(baseAsid, dva, dva, 1'b0, 1'b1);
		checkLookup(baseAsid, dva, dva, 1'b1, 1'b0);
		checkLookup(baseAsid, iva, iva, 1'b0, 1'b0);

		testName = "asid";
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			pickAddr(modelEntry[i].vpn2, iva);
			pickAddr(modelEntry[i].vpn2, dva);
			checkLookup(~baseAsid, iva, dva, 1'b0, 1'b1);
		end

		testName = "random write";
		for (int k = 0; k < 3; k++) begin
			randomEntry(e, g0, g1);
			takeBits(32, bits);
			writeEntry(OP_WRITE_RANDOM, bits, e, g0, g1);
			readCheck(bits[IDX_W-1:0]);
			pickAddr(e.vpn2, iva);
			checkLookup(baseAsid, iva, iva, 1'b1, 1'b0);
		end

		testName = "probe";
		for (int k = 0; k < 4; k++) begin
			takeBits(IDX_W, bits);
			probeCheck(modelEntry[bits[IDX_W-1:0]].vpn2, baseAsid);
		end
		probeCheck(modelEntry[5].vpn2, ~baseAsid);   // Global matches any ASID
		freshVpn2(v);
		probeCheck(v, baseAsid);
		readCheck(4'd6);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/tlb16.sv
`timescale 1ns/1ps
`default_nettype none

module tlb16 (
	input  wire logic                clk,
	input  wire logic                rstN,
	input  wire tlbPkg::vaddrT       instVaddr,
	input  wire tlbPkg::vaddrT       dataVaddr,
	input  wire logic                drd,          // Load
	input  wire logic                dwe,          // Store
	input  wire tlbPkg::tlbOpT       op,
	input  wire tlbPkg::cp0InT       cp0In,
	output tlbPkg::xlateResultT      instResult,
	output tlbPkg::xlateResultT      dataResult,
	output tlbPkg::cp0ViewT          cp0View
);

	import tlbPkg::*;

	logic                   wrEn;
	tlbIdxT                 wrIdx;
	tlbEntryT               wrEntry;
	tlbEntryT [TLB_ENTRIES-1:0] entries;
	logic [TLB_ENTRIES-1:0] present;
	asidT                   curAsid;

	assign curAsid = cp0In.entryHi[ASID_W-1:0];  // Current process ASID

	////////////////////////////////////////////////////////////////////////////
	// Maintenance and storage
	////////////////////////////////////////////////////////////////////////////

	tlbMaint maint_i (
		.clk     (clk),
		.rstN    (rstN),
		.op      (op),
		.cp0In   (cp0In),
		.entries (entries),
		.present (present),
		.wrEn    (wrEn),
		.wrIdx   (wrIdx),
		.wrEntry (wrEntry),
		.cp0View (cp0View)
	);

	tlbEntryArray array_i (
		.clk     (clk),
		.rstN    (rstN),
		.wrEn    (wrEn),
		.wrIdx   (wrIdx),
		.wrEntry (wrEntry),
		.entries (entries),
		.present (present)
	);

	////////////////////////////////////////////////////////////////////////////
	// Translation ports
	////////////////////////////////////////////////////////////////////////////

	// Fetch is always a read access
	tlbLookup instXlate (
		.vaddr   (instVaddr),
		.curAsid (curAsid),
		.load    (1'b1),
		.store   (1'b0),
		.entries (entries),
		.present (present),
		.result  (instResult)
	);

	tlbLookup dataXlate (
		.vaddr   (dataVaddr),
		.curAsid (curAsid),
		.load    (drd),
		.store   (dwe),
		.entries (entries),
		.present (present),
		.result  (dataResult)
	);

endmodule

`default_nettype wire

//--- verilog/tlbMaint.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMaint (
	input  wire logic                                          clk,
	input  wire logic                                          rstN,
	input  wire tlbPkg::tlbOpT                                 op,
	input  wire tlbPkg::cp0InT                                 cp0In,
	input  wire tlbPkg::tlbEntryT [tlbPkg::TLB_ENTRIES-1:0]    entries,
	input  wire logic [tlbPkg::TLB_ENTRIES-1:0]                present,
	output logic                                               wrEn,
	output tlbPkg::tlbIdxT                                     wrIdx,
	output tlbPkg::tlbEntryT                                   wrEntry,
	output tlbPkg::cp0ViewT                                    cp0View
);

	import tlbPkg::*;

	logic                   doProbe;
	logic                   doRead;
	logic                   doWrIdx;
	logic                   doWrRand;
	logic [TLB_ENTRIES-1:0] probeHit;
	logic                   probeFound;
	tlbIdxT                 probeIdx;
	tlbIdxT                 rdIdx;
	tlbEntryT               rdEntry;

	////////////////////////////////////////////////////////////////////////////
	// Op decode
	////////////////////////////////////////////////////////////////////////////

	assign doProbe  = |(op & OP_PROBE);
	assign doRead   = |(op & OP_READ);
	assign doWrIdx  = |(op & OP_WRITE_INDEX);
	assign doWrRand = |(op & OP_WRITE_RANDOM);

	////////////////////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////////////////////

	assign wrEn  = doWrIdx | doWrRand;  // Low whenever no op is strobed
	assign wrIdx = doWrRand ? cp0In.random[IDX_W-1:0] : cp0In.index[IDX_W-1:0];

	// Host words to entry
	always_comb begin
		wrEntry.vpn2 = cp0In.entryHi[ADDR_W-1 -: VPN2_W];
		wrEntry.asid = cp0In.entryHi[ASID_W-1:0];
		wrEntry.g    = cp0In.entryLo0[LO_G] & cp0In.entryLo1[LO_G];  // Both halves global
		wrEntry.pfn0 = cp0In.entryLo0[LO_PFN_LSB +: PFN_W];
		wrEntry.d0   = cp0In.entryLo0[LO_D];
		wrEntry.v0   = cp0In.entryLo0[LO_V];
		wrEntry.pfn1 = cp0In.entryLo1[LO_PFN_LSB +: PFN_W];
		wrEntry.d1   = cp0In.entryLo1[LO_D];
		wrEntry.v1   = cp0In.entryLo1[LO_V];
	end

	////////////////////////////////////////////////////////////////////////////
	// Probe and read
	////////////////////////////////////////////////////////////////////////////

	// Probe uses the EntryHi fields already split out for the write
	always_comb begin
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			probeHit[i] = entryHits(entries[i], present[i], wrEntry.vpn2, wrEntry.asid);
		end
	end

	// Encoder, at most one bit set
	always_comb begin
		probeIdx = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (probeHit[i]) begin
				probeIdx = tlbIdxT'(i);
			end
		end
	end

	assign probeFound = |probeHit;
	assign rdIdx      = cp0In.index[IDX_W-1:0];
	assign rdEntry    = entries[rdIdx];   // Returned even if never written

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cp0View <= '0;
		end else if (doProbe) begin
			cp0View.indexP <= ~probeFound;
			if (probeFound) begin
				cp0View.indexIndex <= probeIdx;  // Miss keeps the old index
			end
		end else if (doRead) begin
			cp0View.entryHiVpn2 <= rdEntry.vpn2;
			cp0View.entryHiAsid <= rdEntry.asid;
			cp0View.entryLo0Pfn <= rdEntry.pfn0;
			cp0View.entryLo0Dv  <= {rdEntry.d0, rdEntry.v0};
			cp0View.entryLo1Pfn <= rdEntry.pfn1;
			cp0View.entryLo1Dv  <= {rdEntry.d1, rdEntry.v1};
			cp0View.entryLoG    <= rdEntry.g;
		end
	end

	// Host must never raise two ops at once
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(op))
		else $error("TLB op not one-hot: %b", op);

	// Entry lands in the array and is live one cycle after the strobe
	assert property (@(posedge clk) disable iff (!rstN)
		wrEn |=> present[$past(wrIdx)] && (entries[$past(wrIdx)] == $past(wrEntry)))
		else $error("TLB write did not reach the array");

endmodule

`default_nettype wire

//--- verilog/tlbLookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlbLookup (
	input  wire tlbPkg::vaddrT                                 vaddr,
	input  wire tlbPkg::asidT                                  curAsid,
	input  wire logic                                          load,
	input  wire logic                                          store,
	input  wire tlbPkg::tlbEntryT [tlbPkg::TLB_ENTRIES-1:0]    entries,
	input  wire logic [tlbPkg::TLB_ENTRIES-1:0]                present,
	output tlbPkg::xlateResultT                                result
);

	import tlbPkg::*;

	logic [TLB_ENTRIES-1:0] hitVec;     // One bit per entry
	tlbEntryT               hitEntry;   // Matching entry or zero on miss
	logic                   anyHit;
	logic                   oddPage;
	logic                   active;     // Access in progress on this port
	pfnT                    selPfn;
	logic                   selV;
	logic                   selD;

	////////////////////////////////////////////////////////////////////////////
	// Associative match
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			hitVec[i] = entryHits(entries[i], present[i],
				vaddr[ADDR_W-1 -: VPN2_W], curAsid);
		end
	end

	// AND-OR mux relies on at most one entry hitting
	always_comb begin
		hitEntry = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (hitVec[i]) begin
				hitEntry = tlbEntryT'(hitEntry | entries[i]);
			end
		end
	end

	assign anyHit = |hitVec;

	////////////////////////////////////////////////////////////////////////////
	// Even/odd select and flags
	////////////////////////////////////////////////////////////////////////////

	assign oddPage = vaddr[ODD_BIT];
	assign selPfn  = oddPage ? hitEntry.pfn1 : hitEntry.pfn0;
	assign selV    = oddPage ? hitEntry.v1 : hitEntry.v0;
	assign selD    = oddPage ? hitEntry.d1 : hitEntry.d0;
	assign active  = load | store;  // Fetch port has load tied high

	always_comb begin
		result.paddr    = anyHit ? {selPfn, vaddr[OFFSET_W-1:0]} : '0;
		result.refill   = active & ~anyHit;
		result.invalid  = active & anyHit & ~selV;
		result.modified = store & anyHit & selV & ~selD;  // Store to a clean page raises TLB mod
	end

	// Duplicate VPN2/ASID pairs would mean the host wrote a bad mapping
	always_comb begin
		assert final ($isunknown(hitVec) || $onehot0(hitVec))
			else $error("Multiple TLB entries match %h", vaddr);
	end

endmodule

`default_nettype wire

//--- verilog/tlbEntryArray.sv
`timescale 1ns/1ps
`default_nettype none

module tlbEntryArray (
	input  wire logic                                          clk,
	input  wire logic                                          rstN,
	input  wire logic                                          wrEn,
	input  wire tlbPkg::tlbIdxT                                wrIdx,
	input  wire tlbPkg::tlbEntryT                              wrEntry,
	output tlbPkg::tlbEntryT [tlbPkg::TLB_ENTRIES-1:0]         entries,
	output logic [tlbPkg::TLB_ENTRIES-1:0]                     present
);

	import tlbPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Present bits
	////////////////////////////////////////////////////////////////////////////

	// An entry can only match once it has been written, so stale
	// contents after power-up never alias address zero
	always_ff @(posedge clk) begin
		if (!rstN) begin
			present <= '0;
		end else if (wrEn) begin
			present[wrIdx] <= 1'b1;   // Stays set, entries are only overwritten
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wrEn) begin
			entries[wrIdx] <= wrEntry;  // Visible to lookups next cycle
		end
	end

	// Index comes from the host INDEX/RANDOM words via the op decoder
	assert property (@(posedge clk) disable iff (!rstN)
		wrEn |-> !$isunknown(wrIdx))
		else $error("TLB write with unknown index");

endmodule

`default_nettype wire

//--- verilog/tlbPkg.sv
`default_nettype none

package tlbPkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes and field positions
	////////////////////////////////////////////////////////////////////////////

	localparam int TLB_ENTRIES = 16;              // Fully associative, no wired set
	localparam int IDX_W       = 4;               // log2 of the entry count
	localparam int ADDR_W      = 32;
	localparam int CP0_W       = 32;              // Width of each CP0 register word
	localparam int OFFSET_W    = 12;              // 4 KB pages only
	localparam int ODD_BIT     = OFFSET_W;        // Picks the odd page of a pair
	localparam int VPN2_LSB    = OFFSET_W + 1;    // Same place in vaddr and EntryHi
	localparam int VPN2_W      = ADDR_W - VPN2_LSB;
	localparam int ASID_W      = 8;               // EntryHi bits 7:0
	localparam int PFN_W       = 20;

	// EntryLo layout
	localparam int LO_PFN_LSB  = 6;               // PFN in 25:6
	localparam int LO_D        = 2;               // Dirty, i.e. writable
	localparam int LO_V        = 1;
	localparam int LO_G        = 0;

	typedef logic [ADDR_W-1:0]  vaddrT;
	typedef logic [ADDR_W-1:0]  paddrT;
	typedef logic [VPN2_W-1:0]  vpn2T;
	typedef logic [ASID_W-1:0]  asidT;
	typedef logic [PFN_W-1:0]   pfnT;
	typedef logic [IDX_W-1:0]   tlbIdxT;
	typedef logic [3:0]         tlbOpT;

	// One-hot op strobes
	localparam tlbOpT OP_PROBE        = 4'b0001;
	localparam tlbOpT OP_READ         = 4'b0010;
	localparam tlbOpT OP_WRITE_INDEX  = 4'b0100;
	localparam tlbOpT OP_WRITE_RANDOM = 4'b1000;

	////////////////////////////////////////////////////////////////////////////
	// Entry, host registers and results
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		vpn2T vpn2;
		asidT asid;
		logic g;     // Ignore ASID on match
		pfnT  pfn0;  // Even page
		logic d0;
		logic v0;
		pfnT  pfn1;  // Odd page
		logic d1;
		logic v1;
	} tlbEntryT;

	typedef struct packed {
		logic [CP0_W-1:0] index;
		logic [CP0_W-1:0] random;    // Counter lives in the host
		logic [CP0_W-1:0] entryHi;
		logic [CP0_W-1:0] entryLo0;
		logic [CP0_W-1:0] entryLo1;
	} cp0InT;

	typedef struct packed {
		logic       indexP;          // Probe failed
		tlbIdxT     indexIndex;
		vpn2T       entryHiVpn2;
		asidT       entryHiAsid;
		pfnT        entryLo0Pfn;
		logic [1:0] entryLo0Dv;      // {D, V}
		pfnT        entryLo1Pfn;
		logic [1:0] entryLo1Dv;
		logic       entryLoG;
	} cp0ViewT;

	typedef struct packed {
		paddrT paddr;
		logic  refill;     // No entry matched
		logic  invalid;    // Matched, half not valid
		logic  modified;   // Store to a clean page
	} xlateResultT;

	// Match rule shared by the lookups and the probe
	function automatic logic entryHits(input tlbEntryT e, input logic pres,
		input vpn2T vpn2, input asidT asid);
		return pres && (e.vpn2 == vpn2) && (e.g || (e.asid == asid));
	endfunction

endpackage

`default_nettype wire
